// ==== hdl/loader_pkg.sv ====
// ====================
// Shared definitions for the download path: kinds, index codes,
// region bases, lane sizing and the memory write word.
// Imported by the receiver, the lanes, the arbiter and the top level.
// ====================
package loader_pkg;

	// Kind of file currently being downloaded
	typedef enum logic [2:0] {
		DL_NONE,
		DL_BIOS,
		DL_EXE,
		DL_CD,
		DL_CDINFO,
		DL_SBI,
		DL_CODE
	} dl_kind_t;

	// Host index codes, CD is matched on the low 6 bits only
	localparam logic [7:0] IDX_BIOS   = 8'd0;
	localparam logic [7:0] IDX_EXE    = 8'd1;
	localparam logic [7:0] IDX_CD     = 8'd2;
	localparam logic [7:0] IDX_SBI    = 8'd250;
	localparam logic [7:0] IDX_CDINFO = 8'd251;
	localparam logic [7:0] IDX_CODE   = 8'd255;

	localparam int ADDR_W = 27;

	// Region bases in byte addresses
	localparam logic [ADDR_W-1:0] BIOS_BASE = 27'h020_0000;
	localparam logic [ADDR_W-1:0] EXE_BASE  = 27'h040_0000;

	localparam int NUM_LANES  = 2;
	localparam int LANE_W     = $clog2(NUM_LANES);
	localparam int LANE_DEPTH = 4;
	localparam int LANE_PTR_W = $clog2(LANE_DEPTH);
	localparam int CREDIT_W   = 3;

	localparam logic [LANE_W-1:0] LANE_MAIN  = 1'd0;
	localparam logic [LANE_W-1:0] LANE_TRACK = 1'd1;

	typedef struct packed {
		logic [LANE_W-1:0] lane;
		logic [ADDR_W-1:0] addr;
		logic [31:0]       data;
	} mem_wr_t;

endpackage

// ==== hdl/cheat_pkg.sv ====
// ====================
// Cheat code layout, seen either as named fields or as halfwords.
// Used by the cheat assembler and the top-level port.
// ====================
package cheat_pkg;

	localparam int CHEAT_HALVES = 8;
	localparam int SLOT_W = $clog2(CHEAT_HALVES);

	// Host slot to halfword index mapping, big endian words
	localparam logic [SLOT_W-1:0] SLOT_SWAP = 3'd6;

	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_fields_t;

	typedef union packed {
		cheat_fields_t                     field;
		logic [CHEAT_HALVES-1:0][15:0] half;
	} cheat_code_t;

endpackage

// ==== hdl/ioctl_receiver.sv ====
// ====================
// Host download receiver. Decodes the index, pairs halfwords into
// memory words, tracks lane credits for the host wait, and flags
// end of EXE/CD downloads and cheat code traffic.
// ====================
`timescale 1ns/1ps

module ioctl_receiver (
	input  logic                                clk_1x,
	input  logic                                arst_n,
	input  logic                                dl_active,
	input  logic [7:0]                          dl_index,
	input  logic [loader_pkg::ADDR_W-1:0]       dl_addr,
	input  logic [15:0]                         dl_data,
	input  logic                                dl_wr,
	input  logic [loader_pkg::NUM_LANES-1:0]    lane_credit,
	output logic                                dl_wait,
	output logic [loader_pkg::NUM_LANES-1:0]    lane_push,
	output loader_pkg::mem_wr_t                 lane_word,
	output logic                                exe_loaded,
	output logic [29:0]                         cd_size,
	output logic                                cd_present,
	output logic                                code_start,
	output logic                                code_wr,
	output logic [2:0]                          code_slot,
	output logic [15:0]                         code_half
);
	import loader_pkg::*;

	dl_kind_t kind_d, kind_q, kind_prev;
	logic ram_kind;
	logic [LANE_W-1:0] lane_sel;
	logic [ADDR_W-1:0] base;
	logic [ADDR_W-1:0] last_addr;
	logic [CREDIT_W-1:0] credit [NUM_LANES];
	logic wr_lo, wr_hi, take;

	// ==================
	// Index decode and routing
	// ==================
	always_comb begin
		kind_d = DL_NONE;
		if (dl_active) begin
			if (dl_index == IDX_BIOS)
				kind_d = DL_BIOS;
			else if (dl_index == IDX_EXE)
				kind_d = DL_EXE;
			else if (dl_index == IDX_SBI)
				kind_d = DL_SBI;
			else if (dl_index == IDX_CDINFO)
				kind_d = DL_CDINFO;
			else if (dl_index == IDX_CODE)
				kind_d = DL_CODE;
			else if (dl_index[5:0] == IDX_CD[5:0])
				kind_d = DL_CD;
		end
	end

	always_comb begin
		ram_kind = 1'b1;
		lane_sel = LANE_MAIN;
		base     = '0;
		case (kind_q)
			DL_BIOS:   base = BIOS_BASE;
			DL_EXE:    base = EXE_BASE;
			DL_CD:     base = '0;
			DL_CDINFO: lane_sel = LANE_TRACK;
			default:   ram_kind = 1'b0;
		endcase
	end

	// Host must hold off while the target lane is out of credit
	assign dl_wait = ram_kind && (credit[lane_sel] == '0);

	assign wr_lo = dl_wr && !dl_addr[1];
	assign wr_hi = dl_wr && dl_addr[1];
	assign take  = wr_hi && ram_kind && !dl_wait;

	// ==================
	// Control state
	// ==================
	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			kind_q     <= DL_NONE;
			kind_prev  <= DL_NONE;
			lane_push  <= '0;
			exe_loaded <= 1'b0;
			cd_present <= 1'b0;
			code_start <= 1'b0;
			code_wr    <= 1'b0;
			for (int i = 0; i < NUM_LANES; i++)
				credit[i] <= CREDIT_W'(LANE_DEPTH);
		end else begin
			kind_q    <= kind_d;
			kind_prev <= kind_q;

			lane_push <= '0;
			if (take)
				lane_push[lane_sel] <= 1'b1;

			// One credit back per word leaving a lane
			for (int i = 0; i < NUM_LANES; i++)
				credit[i] <= credit[i] + CREDIT_W'(lane_credit[i]) - CREDIT_W'(lane_push[i]);

			exe_loaded <= (kind_prev == DL_EXE) && (kind_q != DL_EXE);
			if ((kind_prev == DL_CD) && (kind_q != DL_CD))
				cd_present <= 1'b1;

			code_start <= (kind_d == DL_CODE) && (kind_q != DL_CODE);
			code_wr    <= dl_wr && (kind_q == DL_CODE);
		end
	end

	// ==================
	// Payload
	// ==================
	always_ff @(posedge clk_1x) begin
		if (ram_kind && wr_lo) begin
			lane_word.addr       <= dl_addr + base;
			lane_word.data[15:0] <= dl_data;
		end
		if (take) begin
			lane_word.data[31:16] <= dl_data;
			lane_word.lane        <= lane_sel;
		end

		if (dl_wr && (kind_q == DL_CD))
			last_addr <= dl_addr;
		if ((kind_prev == DL_CD) && (kind_q != DL_CD))
			cd_size <= 30'(last_addr);

		if (dl_wr) begin
			code_slot <= dl_addr[3:1];
			code_half <= dl_data;
		end
	end

endmodule

// ==== hdl/cheat_assembler.sv ====
// ====================
// Builds a 128-bit cheat code from eight host halfwords and
// strobes clear at download start and valid on the last slot.
// ====================
`timescale 1ns/1ps

module cheat_assembler (
	input  logic                   clk_1x,
	input  logic                   arst_n,
	input  logic                   code_start,
	input  logic                   code_wr,
	input  logic [2:0]             code_slot,
	input  logic [15:0]            code_half,
	output logic                   cheat_clear,
	output logic                   cheat_valid,
	output cheat_pkg::cheat_code_t cheat_code
);
	import cheat_pkg::*;

	logic last_slot;

	assign last_slot = (code_slot == SLOT_W'(CHEAT_HALVES - 1));

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			cheat_clear <= 1'b0;
			cheat_valid <= 1'b0;
		end else begin
			cheat_clear <= code_start;
			cheat_valid <= code_wr && last_slot;
		end
	end

	// Slot 0 lands in the low half of flags, slot 7 in the top of replace
	always_ff @(posedge clk_1x) begin
		if (code_wr)
			cheat_code.half[code_slot ^ SLOT_SWAP] <= code_half;
	end

endmodule

// ==== hdl/lane_fifo.sv ====
// ====================
// Circular write buffer for one memory lane. The sender tracks
// space by credits, so no full flag; each pop returns one credit.
// ====================
`timescale 1ns/1ps

module lane_fifo (
	input  logic                clk_1x,
	input  logic                arst_n,
	input  logic                push,
	input  loader_pkg::mem_wr_t push_word,
	input  logic                pop,
	output logic                head_valid,
	output loader_pkg::mem_wr_t head_word,
	output logic                credit
);
	import loader_pkg::*;

	mem_wr_t mem [LANE_DEPTH];
	logic [LANE_PTR_W-1:0] wr_ptr, rd_ptr;
	logic [CREDIT_W-1:0] count;
	logic do_pop;

	assign head_valid = (count != '0);
	assign head_word  = mem[rd_ptr];
	assign do_pop     = pop && head_valid;
	assign credit     = do_pop;

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				if (wr_ptr == LANE_PTR_W'(LANE_DEPTH - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				if (rd_ptr == LANE_PTR_W'(LANE_DEPTH - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
			count <= count + CREDIT_W'(push) - CREDIT_W'(do_pop);
		end
	end

	// Storage
	always_ff @(posedge clk_1x) begin
		if (push)
			mem[wr_ptr] <= push_word;
	end

endmodule

// ==== hdl/mem_write_arbiter.sv ====
// ====================
// Round-robin merge of the lane heads onto the memory write port.
// A stalled grant stays locked so the request holds steady.
// ====================
`timescale 1ns/1ps

module mem_write_arbiter (
	input  logic                             clk_1x,
	input  logic                             arst_n,
	input  logic [loader_pkg::NUM_LANES-1:0] head_valid,
	input  loader_pkg::mem_wr_t              head_word [loader_pkg::NUM_LANES],
	input  logic                             mem_ready,
	output logic [loader_pkg::NUM_LANES-1:0] pop,
	output logic                             mem_valid,
	output loader_pkg::mem_wr_t              mem_req
);
	import loader_pkg::*;

	logic [LANE_W-1:0] rr_ptr, held_lane, sel;
	logic locked, xfer;

	// First valid head at or after the pointer
	always_comb begin : pick
		int cand;
		logic found;
		sel   = rr_ptr;
		found = 1'b0;
		for (int k = 0; k < NUM_LANES; k++) begin
			cand = (int'(rr_ptr) + k) % NUM_LANES;
			if (!found && head_valid[cand]) begin
				sel   = LANE_W'(cand);
				found = 1'b1;
			end
		end
		if (locked)
			sel = held_lane;
	end

	assign mem_valid = |head_valid;
	assign mem_req   = head_word[sel];
	assign xfer      = mem_valid && mem_ready;

	always_comb begin
		pop = '0;
		if (xfer)
			pop[sel] = 1'b1;
	end

	always_ff @(posedge clk_1x or negedge arst_n) begin
		if (!arst_n) begin
			rr_ptr    <= '0;
			held_lane <= '0;
			locked    <= 1'b0;
		end else begin
			locked    <= mem_valid && !mem_ready;
			held_lane <= sel;
			if (xfer)
				rr_ptr <= (sel == LANE_W'(NUM_LANES - 1)) ? '0 : sel + 1'b1;
		end
	end

endmodule

// ==== hdl/loader_top.sv ====
// ====================
// Loading path top level: host receiver, per-lane write buffers,
// memory write merge and cheat code assembly.
// ====================
`timescale 1ns/1ps

module loader_top (
	input  logic                          clk_1x,
	input  logic                          arst_n,
	input  logic                          dl_active,
	input  logic [7:0]                    dl_index,
	input  logic [loader_pkg::ADDR_W-1:0] dl_addr,
	input  logic [15:0]                   dl_data,
	input  logic                          dl_wr,
	output logic                          dl_wait,
	output logic                          mem_valid,
	output loader_pkg::mem_wr_t           mem_req,
	input  logic                          mem_ready,
	output logic                          exe_loaded,
	output logic [29:0]                   cd_size,
	output logic                          cd_present,
	output logic                          cheat_clear,
	output logic                          cheat_valid,
	output cheat_pkg::cheat_code_t        cheat_code
);
	import loader_pkg::*;

	logic [NUM_LANES-1:0] lane_push, lane_credit, head_valid, pop;
	mem_wr_t lane_word;
	mem_wr_t head_word [NUM_LANES];
	logic code_start, code_wr;
	logic [2:0] code_slot;
	logic [15:0] code_half;

	ioctl_receiver u_receiver (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.dl_active   (dl_active),
		.dl_index    (dl_index),
		.dl_addr     (dl_addr),
		.dl_data     (dl_data),
		.dl_wr       (dl_wr),
		.lane_credit (lane_credit),
		.dl_wait     (dl_wait),
		.lane_push   (lane_push),
		.lane_word   (lane_word),
		.exe_loaded  (exe_loaded),
		.cd_size     (cd_size),
		.cd_present  (cd_present),
		.code_start  (code_start),
		.code_wr     (code_wr),
		.code_slot   (code_slot),
		.code_half   (code_half)
	);

	// Lane 0 main memory, lane 1 track info
	for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
		lane_fifo u_lane (
			.clk_1x     (clk_1x),
			.arst_n     (arst_n),
			.push       (lane_push[i]),
			.push_word  (lane_word),
			.pop        (pop[i]),
			.head_valid (head_valid[i]),
			.head_word  (head_word[i]),
			.credit     (lane_credit[i])
		);
	end

	mem_write_arbiter u_arbiter (
		.clk_1x     (clk_1x),
		.arst_n     (arst_n),
		.head_valid (head_valid),
		.head_word  (head_word),
		.mem_ready  (mem_ready),
		.pop        (pop),
		.mem_valid  (mem_valid),
		.mem_req    (mem_req)
	);

	cheat_assembler u_cheat (
		.clk_1x      (clk_1x),
		.arst_n      (arst_n),
		.code_start  (code_start),
		.code_wr     (code_wr),
		.code_slot   (code_slot),
		.code_half   (code_half),
		.cheat_clear (cheat_clear),
		.cheat_valid (cheat_valid),
		.cheat_code  (cheat_code)
	);

endmodule

// ==== tests/loader_assertions.sv ====
// ====================
// Concurrent checks for the loading path, bound into the receiver
// and the arbiter. Inputs that do not apply to a target are tied idle.
// ====================
`timescale 1ns/1ps

module loader_assertions (
	input logic                             clk_1x,
	input logic                             arst_n,
	input logic [loader_pkg::NUM_LANES-1:0] push,
	input logic [loader_pkg::NUM_LANES-1:0] credit_zero,
	input logic                             valid,
	input logic                             ready,
	input loader_pkg::mem_wr_t              req
);

	// A lane is only pushed while its credit is nonzero
	push_has_credit: assert property (@(posedge clk_1x) disable iff (!arst_n)
		(push & credit_zero) == '0)
		else $error("lane push issued with zero credit");

	// Stalled request holds until the transfer
	req_held: assert property (@(posedge clk_1x) disable iff (!arst_n)
		valid && !ready |=> valid && $stable(req))
		else $error("mem_req moved while mem_ready was low");

	idle_in_reset: assert property (@(posedge clk_1x) !arst_n |-> !valid)
		else $error("mem_valid high during reset");

endmodule

bind ioctl_receiver loader_assertions u_rx_checks (
	.clk_1x      (clk_1x),
	.arst_n      (arst_n),
	.push        (lane_push),
	.credit_zero ({credit[1] == '0, credit[0] == '0}),
	.valid       (1'b0),
	.ready       (1'b1),
	.req         ('0)
);

bind mem_write_arbiter loader_assertions u_arb_checks (
	.clk_1x      (clk_1x),
	.arst_n      (arst_n),
	.push        ('0),
	.credit_zero ('0),
	.valid       (mem_valid),
	.ready       (mem_ready),
	.req         (mem_req)
);

// ==== tests/tb_loader_top.sv ====
// ====================
// Testbench for the loading path. Applies a table of downloads,
// scores memory writes per lane under a random memory ready, and
// checks the end-of-download flags and the cheat code layout.
// ====================
`timescale 1ns/1ps

module tb_loader_top;
	import loader_pkg::*;
	import cheat_pkg::*;

	localparam int TIMEOUT  = 2000;
	localparam int NUM_ROWS = 8;

	typedef struct packed {
		logic [7:0]        index;
		logic [ADDR_W-1:0] start;
		logic [7:0]        words;
		logic [LANE_W-1:0] lane;
		logic [ADDR_W-1:0] base;
		logic              stall;
	} row_t;

	logic clk_1x, arst_n;
	logic dl_active, dl_wr, dl_wait;
	logic [7:0] dl_index;
	logic [ADDR_W-1:0] dl_addr;
	logic [15:0] dl_data;
	logic mem_valid, mem_ready;
	mem_wr_t mem_req;
	logic exe_loaded, cd_present, cheat_clear, cheat_valid;
	logic [29:0] cd_size;
	cheat_code_t cheat_code;

	row_t stim_rows [NUM_ROWS];
	mem_wr_t expect_q [NUM_LANES][$];
	cheat_code_t got_code;
	logic hold_ready;
	logic timed_out;
	int xfer_count, exe_count, clear_count, valid_count, wait_count;
	int row_errors, tests_run, tests_bad;

	loader_top uut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #5 clk_1x = ~clk_1x;
	end

	// Memory side accepts about three writes in four
	always @(posedge clk_1x)
		mem_ready <= hold_ready ? 1'b0 : (($urandom % 4) != 0);

	// ====================
	// Helpers
	// ====================
	task automatic note_timeout(input string what);
		$display("timeout while %s", what);
		timed_out = 1'b1;
		row_errors++;
	endtask

	task automatic expect_equal(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got == exp) else begin
			$display("FAILED %s got %0h expected %0h", name, got, exp);
			row_errors++;
		end
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (row_errors != 0)
			tests_bad++;
		$display("test %0d %s: %0d errors", tests_run, name, row_errors);
		row_errors = 0;
	endtask

	task automatic host_write(input logic [ADDR_W-1:0] addr, input logic [15:0] data);
		@(posedge clk_1x);
		dl_addr <= addr;
		dl_data <= data;
		dl_wr   <= 1'b1;
		@(posedge clk_1x);
		dl_wr   <= 1'b0;
	endtask

	// Sampled in an idle cycle, so no push is pending on the credits
	task automatic wait_for_credit;
		int t;
		t = 0;
		@(negedge clk_1x);
		while (dl_wait && t < TIMEOUT && !timed_out) begin
			@(negedge clk_1x);
			t++;
		end
		if (dl_wait && !timed_out)
			note_timeout("waiting for dl_wait to fall");
	endtask

	task automatic wait_drain;
		int t;
		t = 0;
		while (expect_q[0].size() + expect_q[1].size() != 0 && t < TIMEOUT && !timed_out) begin
			@(negedge clk_1x);
			t++;
		end
		if (expect_q[0].size() + expect_q[1].size() != 0 && !timed_out)
			note_timeout("waiting for memory writes to drain");
	endtask

	task automatic score_write;
		mem_wr_t exp;
		xfer_count++;
		assert (expect_q[mem_req.lane].size() != 0) else begin
			$display("memory write on lane %0d with nothing expected", mem_req.lane);
			row_errors++;
		end
		if (expect_q[mem_req.lane].size() != 0) begin
			exp = expect_q[mem_req.lane].pop_front();
			expect_equal("mem_req.addr", 128'(mem_req.addr), 128'(exp.addr));
			expect_equal("mem_req.data", 128'(mem_req.data), 128'(exp.data));
		end
	endtask

	// Outputs are stable at the falling edge
	always @(negedge clk_1x) begin
		if (arst_n) begin
			if (mem_valid && mem_ready)
				score_write();
			if (exe_loaded)
				exe_count++;
			if (cheat_clear)
				clear_count++;
			if (cheat_valid) begin
				valid_count++;
				got_code = cheat_code;
			end
			if (dl_wait)
				wait_count++;
		end
	end

	// ====================
	// One download per table row
	// ====================
	task automatic apply_row(input int r);
		row_t row;
		mem_wr_t exp;
		logic [ADDR_W-1:0] a;
		logic [15:0] lo, hi;
		logic [15:0] halves [CHEAT_HALVES];
		logic ram;
		row = stim_rows[r];
		ram = (row.index != IDX_SBI) && (row.index != IDX_CODE);
		xfer_count  = 0;
		exe_count   = 0;
		clear_count = 0;
		valid_count = 0;
		wait_count  = 0;
		a = row.start;
		@(posedge clk_1x);
		hold_ready <= row.stall;
		dl_index   <= row.index;
		dl_active  <= 1'b1;
		@(posedge clk_1x);
		for (int w = 0; w < int'(row.words); w++) begin
			a  = row.start + ADDR_W'(4 * w);
			lo = 16'(32'hA000 + r * 256 + w);
			hi = 16'(32'h5000 + r * 256 + w);
			if (row.index == IDX_CODE) begin
				// One halfword per slot
				halves[w] = lo;
				host_write(row.start + ADDR_W'(2 * w), lo);
			end else begin
				host_write(a, lo);
				if (row.stall && w == LANE_DEPTH) begin
					@(negedge clk_1x);
					assert (dl_wait) else begin
						$display("dl_wait stayed low with a full lane");
						row_errors++;
					end
					hold_ready <= 1'b0;
				end
				wait_for_credit();
				if (ram) begin
					exp.lane = row.lane;
					exp.addr = a + row.base;
					exp.data = {hi, lo};
					expect_q[row.lane].push_back(exp);
				end
				host_write(a + ADDR_W'(2), hi);
			end
		end
		@(posedge clk_1x);
		dl_active <= 1'b0;
		// End flags follow 2 cycles after the fall
		repeat (4) @(posedge clk_1x);
		wait_drain();
		expect_equal("mem_valid transfers", 128'(xfer_count), ram ? 128'(row.words) : 128'(0));
		expect_equal("exe_loaded pulses", 128'(exe_count), 128'(row.index == IDX_EXE));
		if (row.index == IDX_CD) begin
			expect_equal("cd_present", 128'(cd_present), 128'(1));
			expect_equal("cd_size", 128'(cd_size), 128'(a + ADDR_W'(2)));
		end
		if (row.index == IDX_CODE) begin
			expect_equal("cheat_clear pulses", 128'(clear_count), 128'(1));
			expect_equal("cheat_valid pulses", 128'(valid_count), 128'(1));
			expect_equal("cheat_code.flags", 128'(got_code.field.flags),
				128'({halves[1], halves[0]}));
			expect_equal("cheat_code.addr", 128'(got_code.field.addr),
				128'({halves[3], halves[2]}));
			expect_equal("cheat_code.compare", 128'(got_code.field.compare),
				128'({halves[5], halves[4]}));
			expect_equal("cheat_code.replace", 128'(got_code.field.replace),
				128'({halves[7], halves[6]}));
		end
		if (row.index == IDX_SBI)
			expect_equal("dl_wait high cycles", 128'(wait_count), 128'(0));
		close_test($sformatf("index %0d", row.index));
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		void'($urandom(32'h873f));
		arst_n     = 1'b0;
		dl_active  = 1'b0;
		dl_index   = '0;
		dl_addr    = '0;
		dl_data    = '0;
		dl_wr      = 1'b0;
		mem_ready  = 1'b0;
		hold_ready = 1'b0;
		timed_out  = 1'b0;
		row_errors = 0;
		tests_run  = 0;
		tests_bad  = 0;

		// index, start, words, lane, base, stall
		stim_rows[0] = '{IDX_BIOS,   27'h000_0100, 8'd6, 1'b0, 27'h020_0000, 1'b0};
		stim_rows[1] = '{IDX_EXE,    27'h000_0040, 8'd5, 1'b0, 27'h040_0000, 1'b0};
		stim_rows[2] = '{IDX_CD,     27'h001_0000, 8'd7, 1'b0, 27'h000_0000, 1'b0};
		stim_rows[3] = '{IDX_CDINFO, 27'h000_0200, 8'd6, 1'b1, 27'h000_0000, 1'b0};
		stim_rows[4] = '{IDX_CDINFO, 27'h000_0800, 8'd7, 1'b1, 27'h000_0000, 1'b1};
		stim_rows[5] = '{IDX_BIOS,   27'h000_0400, 8'd6, 1'b0, 27'h020_0000, 1'b1};
		stim_rows[6] = '{IDX_CODE,   27'h000_0020, 8'd8, 1'b0, 27'h000_0000, 1'b0};
		stim_rows[7] = '{IDX_SBI,    27'h000_0400, 8'd4, 1'b0, 27'h000_0000, 1'b0};

		repeat (4) @(posedge clk_1x);
		@(negedge clk_1x);
		expect_equal("dl_wait", 128'(dl_wait), 128'(0));
		expect_equal("mem_valid", 128'(mem_valid), 128'(0));
		expect_equal("exe_loaded", 128'(exe_loaded), 128'(0));
		expect_equal("cheat_clear", 128'(cheat_clear), 128'(0));
		expect_equal("cheat_valid", 128'(cheat_valid), 128'(0));
		expect_equal("cd_present", 128'(cd_present), 128'(0));
		repeat (4) @(posedge clk_1x);
		arst_n <= 1'b1;
		close_test("reset");

		for (int r = 0; r < NUM_ROWS && !timed_out; r++)
			apply_row(r);

		$display("summary: %0d run, %0d passed, %0d with errors",
			tests_run, tests_run - tests_bad, tests_bad);
		if (tests_bad == 0 && !timed_out)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== loader_top.f ====
hdl/loader_pkg.sv
hdl/cheat_pkg.sv
hdl/ioctl_receiver.sv
hdl/cheat_assembler.sv
hdl/lane_fifo.sv
hdl/mem_write_arbiter.sv
hdl/loader_top.sv
tests/loader_assertions.sv
tests/tb_loader_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile the loader testbench with Verilator, run it and judge the log

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_loader_top -Mdir "$OBJ" -o sim_loader -f loader_top.f
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

"./$OBJ/sim_loader" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
	echo "FAIL: no pass line in $LOG"
	exit 1
fi
echo "PASS"
exit 0
